//--- test/ising_cases.txt
# J: eight J rows in hex, row 0 first, coupling j in nibble j
# F: eight flip masks in hex, entry 0 first
# C: case name, iterations, initial spin (hex), credit policy (prompt, hold, restart)
# R: expected spin (hex) and energy (decimal) of one iteration of the case above
J D0000021 000003F0 0000E200 00040000 00C00001 02000000 80000000 0000A005
F 01 81 3C FF 10 42 07 A5
C single_iter 1 00 prompt
R 01 14
C multi_iter 4 5A prompt
R 5B -22
R DA 12
R E6 -12
R 19 -12
C back_pressure 5 F0 hold
R F1 4
R 70 -2
R 4C -6
R B3 -6
R A3 -20
C start_while_busy 3 33 restart
R 32 28
R B3 -6
R 8F -2

//--- sources.f
+incdir+include
src/ising_pkg.sv
src/ising_cfg_regs.sv
src/ising_l1_mem.sv
src/ising_energy_calc.sv
src/ising_sweep_ctrl.sv
src/ising_core_top.sv
test/tb_ising_core.sv

//--- Bender.yml
package:
  name: ising_core

sources:
  - src/ising_pkg.sv
  - src/ising_cfg_regs.sv
  - src/ising_l1_mem.sv
  - src/ising_energy_calc.sv
  - src/ising_sweep_ctrl.sv
  - src/ising_core_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_ising_core.sv

//--- include/tb_ising_checks.svh
//////////////////////////////////////////////////////////////////////
// Ising core testbench checks
// compare tasks for energy, spin and flag results
//////////////////////////////////////////////////////////////////////
`ifndef TB_ISING_CHECKS_SVH
`define TB_ISING_CHECKS_SVH

task automatic report_fail(input string name);
    $display("Errors found");
    $fatal(1, "%s did not match, stopping", name);
endtask

task automatic check_energy(input string name,
                            input logic signed [ENERGY_W-1:0] exp_v,
                            input logic signed [ENERGY_W-1:0] act_v);
    if (act_v !== exp_v) begin
        $display("** Error: %s expected %0d actual %0d", name, exp_v, act_v);
        report_fail(name);
    end
endtask

task automatic check_spin(input string name,
                          input logic [NUM_SPIN-1:0] exp_v,
                          input logic [NUM_SPIN-1:0] act_v);
    if (act_v !== exp_v) begin
        $display("** Error: %s expected %b actual %b", name, exp_v, act_v);
        report_fail(name);
    end
endtask

task automatic check_flag(input string name,
                          input logic exp_v,
                          input logic act_v);
    if (act_v !== exp_v) begin
        $display("** Error: %s expected %b actual %b", name, exp_v, act_v);
        report_fail(name);
    end
endtask

`endif

//--- test/tb_ising_core.sv
//////////////////////////////////////////////////////////////////////
// Ising core testbench
// case file driven sweeps with credit back-pressure and result checks
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_ising_core import ising_pkg::*; ();

    `include "tb_ising_checks.svh"

    localparam int CLK_HALF_NS        = 4;
    localparam int DRIVE_DELAY_NS     = 1;
    localparam int RESET_CYCLES       = 4;
    localparam int IDLE_CYCLES        = 12;
    localparam int HOLD_CYCLES        = 40;
    localparam int CREDIT_DELAY_MAX   = 8;
    localparam int ITER_CYCLE_BOUND   = 40;
    localparam int RESULT_WAIT_CYCLES = 200;
    localparam int MARGIN_CYCLES      = 200;

    logic                       clk = 1'b0;
    logic                       arst_n;
    logic                       host_we;
    host_target_e               host_sel;
    logic [HOST_ADDR_W-1:0]     host_addr;
    logic [HOST_DATA_W-1:0]     host_wdata;
    logic                       credit_return;
    logic                       busy;
    logic                       res_valid;
    logic signed [ENERGY_W-1:0] res_energy;
    logic [NUM_SPIN-1:0]        res_spin;

    // case file contents
    logic [J_ROW_W-1:0]         j_rows [NUM_SPIN];
    logic [NUM_SPIN-1:0]        flip_masks [FLIP_DEPTH];
    string                      case_name [$];
    int                         case_iters [$];
    logic [NUM_SPIN-1:0]        case_spin [$];
    string                      case_policy [$];
    int                         case_first [$];
    logic [NUM_SPIN-1:0]        exp_spin [$];
    logic signed [ENERGY_W-1:0] exp_energy [$];

    int          total_iters     = 0;
    int          results_total   = 0;
    int          results_seen    = 0;
    int          credits_owed    = 0;
    bit          hold_credits    = 1'b0;
    int          timeout_cycles  = 0;
    int unsigned lcg_state       = 96;

    ising_core_top i_ising_core_top (
        .clk_i           (clk          ),
        .arst_n_i        (arst_n       ),
        .host_we_i       (host_we      ),
        .host_sel_i      (host_sel     ),
        .host_addr_i     (host_addr    ),
        .host_wdata_i    (host_wdata   ),
        .credit_return_i (credit_return),
        .busy_o          (busy         ),
        .res_valid_o     (res_valid    ),
        .res_energy_o    (res_energy   ),
        .res_spin_o      (res_spin     )
    );

    // 8 ns period
    always #(CLK_HALF_NS) clk = ~clk;

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // every result pulse on the output, counted apart from the case checks
    always @(negedge clk) begin
        if (res_valid === 1'b1) begin
            results_total++;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // case file reader

    task automatic load_cases();
        int          fd;
        int          n;
        int          iters;
        int          energy;
        string       line;
        string       tag;
        string       name;
        string       policy;
        logic [31:0] word;
        fd = $fopen("test/ising_cases.txt", "r");
        if (fd == 0) begin
            $display("Errors found");
            $fatal(1, "cannot open the case file test/ising_cases.txt");
        end
        while ($fgets(line, fd) > 0) begin
            n = $sscanf(line, "%s", tag);
            if (n < 1 || tag.getc(0) == "#") begin
                continue;
            end
            if (tag == "J") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", tag, j_rows[0], j_rows[1],
                            j_rows[2], j_rows[3], j_rows[4], j_rows[5], j_rows[6], j_rows[7]);
            end else if (tag == "F") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", tag, flip_masks[0],
                            flip_masks[1], flip_masks[2], flip_masks[3], flip_masks[4],
                            flip_masks[5], flip_masks[6], flip_masks[7]);
            end else if (tag == "C") begin
                n = $sscanf(line, "%s %s %d %h %s", tag, name, iters, word, policy);
                case_name.push_back(name);
                case_iters.push_back(iters);
                case_spin.push_back(word[NUM_SPIN-1:0]);
                case_policy.push_back(policy);
                case_first.push_back(exp_spin.size());
                total_iters += iters;
            end else if (tag == "R") begin
                n = $sscanf(line, "%s %h %d", tag, word, energy);
                exp_spin.push_back(word[NUM_SPIN-1:0]);
                exp_energy.push_back(ENERGY_W'(energy));
            end
        end
        $fclose(fd);
        if (exp_spin.size() != total_iters || case_name.size() == 0) begin
            $display("Errors found");
            $fatal(1, "case file has %0d result lines for %0d iterations",
                   exp_spin.size(), total_iters);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // host port and result stream

    task automatic host_write(input host_target_e sel,
                              input logic [HOST_ADDR_W-1:0] addr,
                              input logic [HOST_DATA_W-1:0] data);
        @(posedge clk);
        #(DRIVE_DELAY_NS);
        host_we    = 1'b1;
        host_sel   = sel;
        host_addr  = addr;
        host_wdata = data;
        @(posedge clk);
        #(DRIVE_DELAY_NS);
        host_we    = 1'b0;
    endtask

    task automatic wait_for_result(input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (res_valid !== 1'b1 && cycles < RESULT_WAIT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (res_valid !== 1'b1) begin
            $display("Errors found");
            $fatal(1, "no result arrived for %s within %0d cycles", what, RESULT_WAIT_CYCLES);
        end
    endtask

    task automatic collect_results(input int c);
        int    idx;
        string name;
        for (int k = 0; k < case_iters[c]; k++) begin
            idx  = case_first[c] + k;
            name = $sformatf("%s_iter%0d", case_name[c], k);
            wait_for_result(name);
            check_spin({name, "_spin"}, exp_spin[idx], res_spin);
            check_energy({name, "_energy"}, exp_energy[idx], res_energy);
            check_flag({name, "_busy"}, 1'b1, busy);
            results_seen++;
            credits_owed++;
        end
        // busy drops the cycle after the last result
        @(negedge clk);
        check_flag({case_name[c], "_busy_after_last"}, 1'b0, busy);
    endtask

    task automatic return_credits(input int n);
        int returned;
        int delay;
        returned = 0;
        while (returned < n) begin
            wait (credits_owed > 0 && !hold_credits);
            delay = int'(next_random() % CREDIT_DELAY_MAX);
            repeat (delay) @(posedge clk);
            @(posedge clk);
            #(DRIVE_DELAY_NS);
            credit_return = 1'b1;
            @(posedge clk);
            #(DRIVE_DELAY_NS);
            credit_return = 1'b0;
            credits_owed--;
            returned++;
        end
    endtask

    // all credits spent, the core must stall with busy held
    task automatic watch_backpressure(input int c);
        wait (results_seen == RES_CREDITS);
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_flag({case_name[c], "_stall_valid"}, 1'b0, res_valid);
            check_flag({case_name[c], "_stall_busy"}, 1'b1, busy);
        end
        hold_credits = 1'b0;
    endtask

    task automatic inject_start(input int c);
        wait (results_seen >= 1);
        @(negedge clk);
        check_flag({case_name[c], "_busy_at_restart"}, 1'b1, busy);
        host_write(TGT_CFG, CFG_START, 32'h1);
    endtask

    task automatic check_idle(input string name);
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_flag({name, "_idle_valid"}, 1'b0, res_valid);
            check_flag({name, "_idle_busy"}, 1'b0, busy);
        end
    endtask

    task automatic run_case(input int c);
        results_seen = 0;
        hold_credits = (case_policy[c] == "hold");
        host_write(TGT_CFG, CFG_ITER, HOST_DATA_W'(case_iters[c]));
        host_write(TGT_CFG, CFG_SPIN_INIT, HOST_DATA_W'(case_spin[c]));
        host_write(TGT_CFG, CFG_START, 32'h1);
        fork
            collect_results(c);
            return_credits(case_iters[c]);
            begin
                if (case_policy[c] == "hold") begin
                    watch_backpressure(c);
                end else if (case_policy[c] == "restart") begin
                    inject_start(c);
                end
            end
        join
        check_idle(case_name[c]);
    endtask

    ////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        arst_n        = 1'b0;
        host_we       = 1'b0;
        host_sel      = TGT_CFG;
        host_addr     = '0;
        host_wdata    = '0;
        credit_return = 1'b0;
        load_cases();
        timeout_cycles = total_iters * (ITER_CYCLE_BOUND + CREDIT_DELAY_MAX)
                       + case_name.size() * (HOLD_CYCLES + IDLE_CYCLES + 8)
                       + MARGIN_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY_NS);
        arst_n = 1'b1;
        check_idle("after_reset");
        for (int r = 0; r < NUM_SPIN; r++) begin
            host_write(TGT_JMEM, HOST_ADDR_W'(r), j_rows[r]);
        end
        for (int f = 0; f < FLIP_DEPTH; f++) begin
            host_write(TGT_FLIP, HOST_ADDR_W'(f), HOST_DATA_W'(flip_masks[f]));
        end
        check_idle("after_load");
        for (int c = 0; c < case_name.size(); c++) begin
            run_case(c);
        end
        if (results_total != total_iters) begin
            $display("Errors found");
            $fatal(1, "saw %0d results, expected %0d", results_total, total_iters);
        end else begin
            $display("No errors");
            $finish;
        end
    end

    // watchdog, bound scales with the iterations in the case file
    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles + RESET_CYCLES) @(posedge clk);
        $display("Errors found");
        $fatal(1, "simulation timed out after %0d cycles", timeout_cycles);
    end

endmodule

`default_nettype wire

//--- src/ising_core_top.sv
//////////////////////////////////////////////////////////////////////
// Ising core top level
// config registers, J and flip memories, sweep controller, energy
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ising_core_top import ising_pkg::*; (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       host_we_i,
    input  host_target_e               host_sel_i,
    input  logic [HOST_ADDR_W-1:0]     host_addr_i,
    input  logic [HOST_DATA_W-1:0]     host_wdata_i,
    input  logic                       credit_return_i,
    output logic                       busy_o,
    output logic                       res_valid_o,
    output logic signed [ENERGY_W-1:0] res_energy_o,
    output logic [NUM_SPIN-1:0]        res_spin_o
);

    logic                       start;
    logic [ITER_W-1:0]          iter_num;
    logic [NUM_SPIN-1:0]        spin_init;
    logic                       flip_ren;
    logic [FLIP_ADDR_W-1:0]     flip_raddr;
    logic [NUM_SPIN-1:0]        flip_rdata;
    logic                       j_ren;
    logic [SPIN_IDX_W-1:0]      j_raddr;
    logic [J_ROW_W-1:0]         j_rdata;
    logic                       row_valid;
    logic                       row_last;
    logic [SPIN_IDX_W-1:0]      row_idx;
    logic [J_ROW_W-1:0]         j_row;
    logic [NUM_SPIN-1:0]        spin;
    logic                       energy_valid;
    logic signed [ENERGY_W-1:0] energy;

    ////////////////////////////////////////////////////////////////////
    // host side

    ising_cfg_regs i_cfg_regs (
        .clk_i        (clk_i                   ),
        .arst_n_i     (arst_n_i                ),
        .host_we_i    (host_we_i               ),
        .host_sel_i   (host_sel_i              ),
        .host_addr_i  (cfg_addr_e'(host_addr_i)),
        .host_wdata_i (host_wdata_i            ),
        .busy_i       (busy_o                  ),
        .start_o      (start                   ),
        .iter_num_o   (iter_num                ),
        .spin_init_o  (spin_init               )
    );

    ising_l1_mem #(
        .DEPTH        (NUM_SPIN                ),
        .WIDTH        (J_ROW_W                 ),
        .TARGET       (TGT_JMEM                )
    ) i_l1_mem_j (
        .clk_i        (clk_i                   ),
        .arst_n_i     (arst_n_i                ),
        .host_we_i    (host_we_i               ),
        .host_sel_i   (host_sel_i              ),
        .host_addr_i  (host_addr_i             ),
        .host_wdata_i (host_wdata_i            ),
        .ren_i        (j_ren                   ),
        .raddr_i      (j_raddr                 ),
        .rdata_o      (j_rdata                 )
    );

    ising_l1_mem #(
        .DEPTH        (FLIP_DEPTH              ),
        .WIDTH        (NUM_SPIN                ),
        .TARGET       (TGT_FLIP                )
    ) i_l1_mem_flip (
        .clk_i        (clk_i                   ),
        .arst_n_i     (arst_n_i                ),
        .host_we_i    (host_we_i               ),
        .host_sel_i   (host_sel_i              ),
        .host_addr_i  (host_addr_i             ),
        .host_wdata_i (host_wdata_i            ),
        .ren_i        (flip_ren                ),
        .raddr_i      (flip_raddr              ),
        .rdata_o      (flip_rdata              )
    );

    ////////////////////////////////////////////////////////////////////
    // compute side

    ising_sweep_ctrl i_sweep_ctrl (
        .clk_i           (clk_i           ),
        .arst_n_i        (arst_n_i        ),
        .start_i         (start           ),
        .iter_num_i      (iter_num        ),
        .spin_init_i     (spin_init       ),
        .flip_ren_o      (flip_ren        ),
        .flip_raddr_o    (flip_raddr      ),
        .flip_rdata_i    (flip_rdata      ),
        .j_ren_o         (j_ren           ),
        .j_raddr_o       (j_raddr         ),
        .j_rdata_i       (j_rdata         ),
        .row_valid_o     (row_valid       ),
        .row_last_o      (row_last        ),
        .row_idx_o       (row_idx         ),
        .j_row_o         (j_row           ),
        .spin_o          (spin            ),
        .energy_valid_i  (energy_valid    ),
        .energy_i        (energy          ),
        .credit_return_i (credit_return_i ),
        .busy_o          (busy_o          ),
        .res_valid_o     (res_valid_o     ),
        .res_energy_o    (res_energy_o    ),
        .res_spin_o      (res_spin_o      )
    );

    ising_energy_calc i_energy_calc (
        .clk_i           (clk_i           ),
        .arst_n_i        (arst_n_i        ),
        .row_valid_i     (row_valid       ),
        .row_last_i      (row_last        ),
        .row_idx_i       (row_idx         ),
        .j_row_i         (j_row           ),
        .spin_i          (spin            ),
        .energy_valid_o  (energy_valid    ),
        .energy_o        (energy          )
    );

endmodule

`default_nettype wire

//--- src/ising_sweep_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Ising sweep controller
// iteration FSM, memory reads, spin update and result credits
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ising_sweep_ctrl import ising_pkg::*; (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       start_i,
    input  logic [ITER_W-1:0]          iter_num_i,
    input  logic [NUM_SPIN-1:0]        spin_init_i,
    output logic                       flip_ren_o,
    output logic [FLIP_ADDR_W-1:0]     flip_raddr_o,
    input  logic [NUM_SPIN-1:0]        flip_rdata_i,
    output logic                       j_ren_o,
    output logic [SPIN_IDX_W-1:0]      j_raddr_o,
    input  logic [J_ROW_W-1:0]         j_rdata_i,
    output logic                       row_valid_o,
    output logic                       row_last_o,
    output logic [SPIN_IDX_W-1:0]      row_idx_o,
    output logic [J_ROW_W-1:0]         j_row_o,
    output logic [NUM_SPIN-1:0]        spin_o,
    input  logic                       energy_valid_i,
    input  logic signed [ENERGY_W-1:0] energy_i,
    input  logic                       credit_return_i,
    output logic                       busy_o,
    output logic                       res_valid_o,
    output logic signed [ENERGY_W-1:0] res_energy_o,
    output logic [NUM_SPIN-1:0]        res_spin_o
);

    sweep_state_e          state_q;
    logic                  flip_wait_q;
    logic [SPIN_IDX_W-1:0] row_cnt_q;
    logic [ITER_W-1:0]     iter_idx_q;
    logic [ITER_W-1:0]     iter_num_q;
    logic [NUM_SPIN-1:0]   spin_q;
    logic [CREDIT_W-1:0]   credit_cnt_q;
    logic                  spend;
    logic                  row_last;

    // a credit is taken when the iteration begins, not at emission
    assign spend    = (state_q == ST_WAIT_CREDIT) && (credit_cnt_q != '0);
    assign row_last = (row_cnt_q == SPIN_IDX_W'(NUM_SPIN - 1));

    assign busy_o       = (state_q != ST_IDLE);
    assign flip_ren_o   = (state_q == ST_FLIP_RD) && !flip_wait_q;
    assign flip_raddr_o = iter_idx_q[FLIP_ADDR_W-1:0];
    assign j_ren_o      = (state_q == ST_ROW_RD);
    assign j_raddr_o    = row_cnt_q;
    assign j_row_o      = j_rdata_i;
    assign spin_o       = spin_q;

    ////////////////////////////////////////////////////////////////////
    // FSM

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= ST_IDLE;
            flip_wait_q  <= 1'b0;
            row_cnt_q    <= '0;
            iter_idx_q   <= '0;
            iter_num_q   <= '0;
            spin_q       <= '0;
            credit_cnt_q <= CREDIT_W'(RES_CREDITS);
            res_valid_o  <= 1'b0;
        end else begin
            credit_cnt_q <= credit_cnt_q + CREDIT_W'(credit_return_i) - CREDIT_W'(spend);
            res_valid_o  <= 1'b0;
            unique case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        spin_q     <= spin_init_i;
                        iter_num_q <= iter_num_i;
                        iter_idx_q <= '0;
                        state_q    <= ST_WAIT_CREDIT;
                    end
                end
                // spin state is frozen while no credit is left
                ST_WAIT_CREDIT: begin
                    if (spend) begin
                        state_q <= ST_FLIP_RD;
                    end
                end
                // first cycle issues the read, second applies the mask
                ST_FLIP_RD: begin
                    flip_wait_q <= !flip_wait_q;
                    if (flip_wait_q) begin
                        spin_q    <= spin_q ^ flip_rdata_i;
                        row_cnt_q <= '0;
                        state_q   <= ST_ROW_RD;
                    end
                end
                ST_ROW_RD: begin
                    row_cnt_q <= row_cnt_q + 1'b1;
                    if (row_last) begin
                        state_q <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    if (energy_valid_i) begin
                        res_valid_o <= 1'b1;
                        state_q     <= ST_EMIT;
                    end
                end
                ST_EMIT: begin
                    iter_idx_q <= iter_idx_q + 1'b1;
                    if (iter_idx_q + 1'b1 == iter_num_q) begin
                        state_q <= ST_IDLE;
                    end else begin
                        state_q <= ST_WAIT_CREDIT;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // memory data comes one cycle after the read, delay index and last
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            row_valid_o <= 1'b0;
            row_last_o  <= 1'b0;
            row_idx_o   <= '0;
        end else begin
            row_valid_o <= j_ren_o;
            row_last_o  <= j_ren_o && row_last;
            row_idx_o   <= row_cnt_q;
        end
    end

    // result payload
    always_ff @(posedge clk_i) begin
        if ((state_q == ST_DRAIN) && energy_valid_i) begin
            res_energy_o <= energy_i;
            res_spin_o   <= spin_q;
        end
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        credit_cnt_q <= CREDIT_W'(RES_CREDITS))
        else $error("more credits returned than issued");

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(res_valid_o) |-> (state_q == ST_EMIT))
        else $error("result valid outside the emit state");

endmodule

`default_nettype wire

//--- src/ising_energy_calc.sv
//////////////////////////////////////////////////////////////////////
// Ising energy calculator
// three-stage pipe: sign-corrected couplings, row sum, accumulation
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ising_energy_calc import ising_pkg::*; (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       row_valid_i,
    input  logic                       row_last_i,
    input  logic [SPIN_IDX_W-1:0]      row_idx_i,
    input  logic [J_ROW_W-1:0]         j_row_i,
    input  logic [NUM_SPIN-1:0]        spin_i,
    output logic                       energy_valid_o,
    output logic signed [ENERGY_W-1:0] energy_o
);

    // one extra bit so that -(-8) fits
    logic signed [BIT_J:0]    term_d [NUM_SPIN];
    logic signed [BIT_J:0]    term_q [NUM_SPIN];
    logic signed [ENERGY_W-1:0] row_sum_d;
    logic signed [ENERGY_W-1:0] row_sum_q;
    logic signed [ENERGY_W-1:0] acc_q;
    logic v1_q, last1_q;
    logic v2_q, last2_q;

    ////////////////////////////////////////////////////////////////////
    // stage 1: J[i][j] * s_i * s_j

    // equal spins keep the coupling, opposite spins negate it
    always_comb begin
        for (int j = 0; j < NUM_SPIN; j++) begin
            term_d[j] = signed'(j_row_i[j*BIT_J +: BIT_J]);
            if (spin_i[row_idx_i] != spin_i[j]) begin
                term_d[j] = -term_d[j];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        term_q <= term_d;
    end

    ////////////////////////////////////////////////////////////////////
    // stage 2: row sum

    always_comb begin
        row_sum_d = '0;
        for (int j = 0; j < NUM_SPIN; j++) begin
            row_sum_d = row_sum_d + term_q[j];
        end
    end

    always_ff @(posedge clk_i) begin
        row_sum_q <= row_sum_d;
    end

    // valid and last ride along with the data
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            v1_q    <= 1'b0;
            last1_q <= 1'b0;
            v2_q    <= 1'b0;
            last2_q <= 1'b0;
        end else begin
            v1_q    <= row_valid_i;
            last1_q <= row_valid_i && row_last_i;
            v2_q    <= v1_q;
            last2_q <= last1_q;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // stage 3: accumulate, negate on the last row

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_q          <= '0;
            energy_o       <= '0;
            energy_valid_o <= 1'b0;
        end else begin
            energy_valid_o <= 1'b0;
            if (v2_q && last2_q) begin
                energy_o       <= -(acc_q + row_sum_q);
                energy_valid_o <= 1'b1;
                acc_q          <= '0;
            end else if (v2_q) begin
                acc_q <= acc_q + row_sum_q;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/ising_l1_mem.sv
//////////////////////////////////////////////////////////////////////
// Ising L1 memory
// register array with host write port and 1-cycle engine read port
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ising_l1_mem import ising_pkg::*; #(
    parameter int           DEPTH  = NUM_SPIN,
    parameter int           WIDTH  = J_ROW_W,
    parameter host_target_e TARGET = TGT_JMEM
) (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     host_we_i,
    input  host_target_e             host_sel_i,
    input  logic [HOST_ADDR_W-1:0]   host_addr_i,
    input  logic [HOST_DATA_W-1:0]   host_wdata_i,
    input  logic                     ren_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output logic [WIDTH-1:0]         rdata_o
);

    logic [WIDTH-1:0] mem_q [DEPTH];

    // host side, only writes aimed at this instance
    always_ff @(posedge clk_i) begin
        if (host_we_i && (host_sel_i == TARGET)) begin
            mem_q[host_addr_i] <= host_wdata_i[WIDTH-1:0];
        end
    end

    // engine side, data holds until the next read
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_o <= '0;
        end else if (ren_i) begin
            rdata_o <= mem_q[raddr_i];
        end
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ren_i |-> (int'(raddr_i) < DEPTH))
        else $error("read address beyond memory depth");

endmodule

`default_nettype wire

//--- src/ising_cfg_regs.sv
//////////////////////////////////////////////////////////////////////
// Ising configuration registers
// iteration count, initial spin and start pulse from host writes
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ising_cfg_regs import ising_pkg::*; (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   host_we_i,
    input  host_target_e           host_sel_i,
    input  cfg_addr_e              host_addr_i,
    input  logic [HOST_DATA_W-1:0] host_wdata_i,
    input  logic                   busy_i,
    output logic                   start_o,
    output logic [ITER_W-1:0]      iter_num_o,
    output logic [NUM_SPIN-1:0]    spin_init_o
);

    logic cfg_we;

    assign cfg_we = host_we_i && (host_sel_i == TGT_CFG);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            start_o     <= 1'b0;
            iter_num_o  <= '0;
            spin_init_o <= '0;
        end else begin
            start_o <= 1'b0;
            if (cfg_we) begin
                unique case (host_addr_i)
                    CFG_ITER:      iter_num_o  <= host_wdata_i[ITER_W-1:0];
                    CFG_SPIN_INIT: spin_init_o <= host_wdata_i[NUM_SPIN-1:0];
                    // a pulse still in flight counts as busy too,
                    // the controller raises busy one cycle later
                    CFG_START:     start_o     <= !busy_i && !start_o;
                    default:       ;
                endcase
            end
        end
    end

    // busy comes back from the controller a cycle after the pulse
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        start_o |-> !busy_i)
        else $error("start pulse issued while the core is busy");

endmodule

`default_nettype wire

//--- src/ising_pkg.sv
//////////////////////////////////////////////////////////////////////
// Ising core package
// sizes, enums and energy width shared by the whole core
//////////////////////////////////////////////////////////////////////
`default_nettype none

package ising_pkg;

    // spin array geometry
    localparam int NUM_SPIN    = 8;
    localparam int SPIN_IDX_W  = 3;

    // one J row holds eight signed couplings, coupling j at bits j*4 upward
    localparam int BIT_J       = 4;
    localparam int J_ROW_W     = NUM_SPIN * BIT_J;

    // flip pattern memory
    localparam int FLIP_DEPTH  = 8;
    localparam int FLIP_ADDR_W = 3;

    // iteration count, legal values 1 to 8
    localparam int ITER_W      = 4;

    // signed energy, |E| <= 8*8*8 so 12 bits leave headroom
    localparam int ENERGY_W    = 12;

    // result flow control
    localparam int RES_CREDITS = 2;
    localparam int CREDIT_W    = 2;

    // host write port
    localparam int HOST_DATA_W = 32;
    localparam int HOST_ADDR_W = 3;

    typedef enum logic [1:0] {
        TGT_CFG,
        TGT_JMEM,
        TGT_FLIP
    } host_target_e;

    typedef enum logic [HOST_ADDR_W-1:0] {
        CFG_ITER,
        CFG_SPIN_INIT,
        CFG_START
    } cfg_addr_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_CREDIT,
        ST_FLIP_RD,
        ST_ROW_RD,
        ST_DRAIN,
        ST_EMIT
    } sweep_state_e;

endpackage

`default_nettype wire
